/* src/udp_rx_defs.svh */
/*
 * UDP audio receiver constants
 * Protocol field values, header byte offsets and the local endpoint
 */
`ifndef UDP_RX_DEFS_SVH
`define UDP_RX_DEFS_SVH

// MII preamble and start-of-frame nibbles, low nibble first on the wire
`define UDP_RX_PREAMBLE_NIBBLE 4'h5
`define UDP_RX_SFD_NIBBLE      4'hD

// Expected header field values
`define UDP_RX_ETHERTYPE_IPV4  16'h0800
`define UDP_RX_IP_VER_IHL      8'h45
`define UDP_RX_IP_PROTO_UDP    8'd17
`define UDP_RX_LOCAL_IP        {8'd192, 8'd168, 8'd1, 8'd128}
`define UDP_RX_LISTEN_PORT     16'd1234

// Byte offsets counted from the first destination MAC byte
`define UDP_RX_OFS_ETHERTYPE   6'd12
`define UDP_RX_OFS_VER_IHL     6'd14
`define UDP_RX_OFS_PROTO       6'd23
`define UDP_RX_OFS_DEST_IP     6'd30
`define UDP_RX_OFS_DEST_PORT   6'd36
`define UDP_RX_OFS_PAYLOAD     6'd42

`endif

/* src/udp_rx_pkg.sv */
/*
 * UDP audio receiver types
 * Widths shared by the MII assembler, header filter, DAC and top level
 */
package udp_rx_pkg;

    // One received or payload byte
    typedef logic [7:0] byte_t;

    // One MII data nibble
    typedef logic [3:0] nibble_t;

    // Byte index in a frame, held at the payload offset
    typedef logic [5:0] hdr_count_t;

    // IPv4 address, first octet in the top byte
    typedef logic [31:0] ipv4_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

endpackage

/* src/mii_rx_assembler.sv */
/*
 * MII receive byte assembler
 * Hunts for the 5-D delimiter while mii_grdv is high, then pairs
 * nibbles into byte strobes, low nibble first, and tracks mii_grxer
 */
`include "udp_rx_defs.svh"

module mii_rx_assembler (
    input  logic                mii_grxck,
    input  logic                rst_125mhz,
    input  udp_rx_pkg::nibble_t mii_grx,
    input  logic                mii_grdv,
    input  logic                mii_grxer,
    output logic                byte_valid,
    output udp_rx_pkg::byte_t   byte_data,
    output logic                frame_start,
    output logic                frame_error
);

    logic                in_data;
    logic                saw_preamble;
    logic                have_low;
    logic                first_byte;
    udp_rx_pkg::nibble_t low_nibble;

    always_ff @(posedge mii_grxck) begin
        if (rst_125mhz) begin
            in_data      <= 1'b0;
            saw_preamble <= 1'b0;
            have_low     <= 1'b0;
            first_byte   <= 1'b0;
            byte_valid   <= 1'b0;
            frame_start  <= 1'b0;
            frame_error  <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
            if (!mii_grdv) begin
                // End of frame, a dangling low nibble is dropped here
                in_data      <= 1'b0;
                saw_preamble <= 1'b0;
                have_low     <= 1'b0;
                first_byte   <= 1'b0;
                frame_error  <= 1'b0;
            end else begin
                if (mii_grxer) begin
                    frame_error <= 1'b1;
                end
                if (!in_data) begin
                    if (saw_preamble && mii_grx == `UDP_RX_SFD_NIBBLE) begin
                        in_data    <= 1'b1;
                        first_byte <= 1'b1;
                    end
                    saw_preamble <= (mii_grx == `UDP_RX_PREAMBLE_NIBBLE);
                end else if (!have_low) begin
                    have_low <= 1'b1;
                    // Announce the frame while its first byte is half built
                    if (first_byte) begin
                        frame_start <= 1'b1;
                        first_byte  <= 1'b0;
                    end
                end else begin
                    have_low   <= 1'b0;
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    // Nibble and byte data registers
    always_ff @(posedge mii_grxck) begin
        if (mii_grdv && in_data) begin
            if (!have_low) begin
                low_nibble <= mii_grx;
            end else begin
                byte_data <= {mii_grx, low_nibble};
            end
        end
    end

endmodule

/* src/udp_header_filter.sv */
/*
 * Ethernet/IPv4/UDP header filter
 * Checks ethertype, version and IHL, protocol, destination IP and
 * destination port on the fly, then forwards the payload bytes
 */
`include "udp_rx_defs.svh"

module udp_header_filter (
    input  logic              mii_grxck,
    input  logic              rst_125mhz,
    input  logic              byte_valid,
    input  udp_rx_pkg::byte_t byte_data,
    input  logic              frame_start,
    input  logic              frame_error,
    output logic              payload_valid,
    output udp_rx_pkg::byte_t payload_data,
    output logic              payload_first
);

    localparam logic [15:0]            ethertype   = `UDP_RX_ETHERTYPE_IPV4;
    localparam udp_rx_pkg::ipv4_addr_t local_ip    = `UDP_RX_LOCAL_IP;
    localparam udp_rx_pkg::udp_port_t  listen_port = `UDP_RX_LISTEN_PORT;

    udp_rx_pkg::hdr_count_t byte_count;
    logic                   match;
    logic                   first_pending;
    logic                   check_en;
    udp_rx_pkg::byte_t      expected;
    logic                   forward;

    // Expected value of the header byte at the current index
    always_comb begin
        check_en = 1'b1;
        expected = 8'h00;
        case (byte_count)
            `UDP_RX_OFS_ETHERTYPE:          expected = ethertype[15:8];
            `UDP_RX_OFS_ETHERTYPE + 6'd1:   expected = ethertype[7:0];
            `UDP_RX_OFS_VER_IHL:            expected = `UDP_RX_IP_VER_IHL;
            `UDP_RX_OFS_PROTO:              expected = `UDP_RX_IP_PROTO_UDP;
            `UDP_RX_OFS_DEST_IP:            expected = local_ip[31:24];
            `UDP_RX_OFS_DEST_IP + 6'd1:     expected = local_ip[23:16];
            `UDP_RX_OFS_DEST_IP + 6'd2:     expected = local_ip[15:8];
            `UDP_RX_OFS_DEST_IP + 6'd3:     expected = local_ip[7:0];
            `UDP_RX_OFS_DEST_PORT:          expected = listen_port[15:8];
            `UDP_RX_OFS_DEST_PORT + 6'd1:   expected = listen_port[7:0];
            default:                        check_en = 1'b0;
        endcase
    end

    // Payload byte of a frame that still matches
    assign forward = byte_valid && match && !frame_error &&
                     (byte_count == `UDP_RX_OFS_PAYLOAD);

    always_ff @(posedge mii_grxck) begin
        if (rst_125mhz) begin
            byte_count    <= '0;
            match         <= 1'b0;
            first_pending <= 1'b0;
            payload_valid <= 1'b0;
            payload_first <= 1'b0;
        end else begin
            payload_valid <= forward;
            payload_first <= forward && first_pending;
            if (frame_start) begin
                byte_count    <= '0;
                match         <= 1'b1;
                first_pending <= 1'b1;
            end else begin
                // An error anywhere drops the rest of the frame
                if (frame_error) begin
                    match <= 1'b0;
                end
                if (byte_valid) begin
                    if (check_en && byte_data != expected) begin
                        match <= 1'b0;
                    end
                    // Index sticks at the payload offset
                    if (byte_count != `UDP_RX_OFS_PAYLOAD) begin
                        byte_count <= byte_count + udp_rx_pkg::hdr_count_t'(1);
                    end
                    if (forward) begin
                        first_pending <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge mii_grxck) begin
        if (forward) begin
            payload_data <= byte_data;
        end
    end

endmodule

/* src/sigma_delta_dac.sv */
/*
 * First-order sigma-delta DAC
 * Adds the held sample into an 8-bit accumulator every cycle and
 * drives the carry out as the pulse density stream
 */
module sigma_delta_dac (
    input  logic              mii_grxck,
    input  logic              rst_125mhz,
    input  logic              sample_valid,
    input  udp_rx_pkg::byte_t sample,
    output logic              pdm_out
);

    udp_rx_pkg::byte_t sample_reg;
    udp_rx_pkg::byte_t acc;

    always_ff @(posedge mii_grxck) begin
        if (rst_125mhz) begin
            sample_reg <= '0;
            acc        <= '0;
            pdm_out    <= 1'b0;
        end else begin
            if (sample_valid) begin
                sample_reg <= sample;
            end
            // Carry rate over 256 cycles equals sample_reg
            {pdm_out, acc} <= {1'b0, acc} + {1'b0, sample_reg};
        end
    end

endmodule

/* src/udp_audio_rx_top.sv */
/*
 * UDP audio receiver top level
 * MII byte assembly, header filtering on port 1234, sigma-delta audio
 * on pdm0_l and the first payload byte of each frame on the LEDs
 */
`include "udp_rx_defs.svh"

module udp_audio_rx_top (
    input  logic                mii_grxck,
    input  logic                rst_125mhz,
    input  udp_rx_pkg::nibble_t mii_grx,
    input  logic                mii_grdv,
    input  logic                mii_grxer,
    output logic                pdm0_l,
    output udp_rx_pkg::byte_t   pmod
);

    logic              byte_valid;
    udp_rx_pkg::byte_t byte_data;
    logic              frame_start;
    logic              frame_error;

    logic              payload_valid;
    udp_rx_pkg::byte_t payload_data;
    logic              payload_first;

    mii_rx_assembler u_mii_rx_assembler (
        .mii_grxck   (mii_grxck),
        .rst_125mhz  (rst_125mhz),
        .mii_grx     (mii_grx),
        .mii_grdv    (mii_grdv),
        .mii_grxer   (mii_grxer),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_start (frame_start),
        .frame_error (frame_error)
    );

    udp_header_filter u_udp_header_filter (
        .mii_grxck     (mii_grxck),
        .rst_125mhz    (rst_125mhz),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .frame_start   (frame_start),
        .frame_error   (frame_error),
        .payload_valid (payload_valid),
        .payload_data  (payload_data),
        .payload_first (payload_first)
    );

    sigma_delta_dac u_sigma_delta_dac (
        .mii_grxck    (mii_grxck),
        .rst_125mhz   (rst_125mhz),
        .sample_valid (payload_valid),
        .sample       (payload_data),
        .pdm_out      (pdm0_l)
    );

    // LEDs show the first payload byte of the latest accepted frame
    always_ff @(posedge mii_grxck) begin
        if (rst_125mhz) begin
            pmod <= '0;
        end else if (payload_first) begin
            pmod <= payload_data;
        end
    end

endmodule

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * 10 ns mii_grxck, synchronous active high reset held for 8 cycles
 */
module tb_clock_gen (
    output logic mii_grxck,
    output logic rst_125mhz
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        mii_grxck = 1'b0;
        forever #5 mii_grxck = ~mii_grxck;
    end

    // Reset drops on the eighth rising edge
    initial begin
        rst_125mhz <= 1'b1;
        repeat (8) @(posedge mii_grxck);
        rst_125mhz <= 1'b0;
    end

endmodule

/* bench/tb_udp_audio_rx.sv */
/*
 * Testbench for the UDP audio receiver
 * Builds MII frames with chosen header fields, checks the LED latch
 * and the sigma-delta pulse density on pdm0_l
 */
module tb_udp_audio_rx;
    timeunit 1ns;
    timeprecision 1ps;

    // Endpoint and protocol values the receiver should accept
    localparam logic [15:0]            good_ethertype = 16'h0800;
    localparam udp_rx_pkg::byte_t      good_proto     = 8'd17;
    localparam udp_rx_pkg::ipv4_addr_t good_ip        = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_rx_pkg::udp_port_t  good_port      = 16'd1234;
    localparam int                     no_error       = -1;
    localparam int                     settle_cycles  = 6;
    localparam int                     reset_timeout  = 50;

    logic                mii_grxck;
    logic                rst_125mhz;
    udp_rx_pkg::nibble_t mii_grx;
    logic                mii_grdv;
    logic                mii_grxer;
    logic                pdm0_l;
    udp_rx_pkg::byte_t   pmod;

    udp_rx_pkg::byte_t frame_q[$];
    udp_rx_pkg::byte_t payload_q[$];
    logic [31:0]       rng_state;
    int                error_count;
    int                check_count;
    int                test_count;

    // What the LEDs and the DAC should show after the last accepted frame
    udp_rx_pkg::byte_t led_now;
    udp_rx_pkg::byte_t level_now;

    tb_clock_gen u_tb_clock_gen (
        .mii_grxck  (mii_grxck),
        .rst_125mhz (rst_125mhz)
    );

    udp_audio_rx_top u_udp_audio_rx_top (
        .mii_grxck  (mii_grxck),
        .rst_125mhz (rst_125mhz),
        .mii_grx    (mii_grx),
        .mii_grdv   (mii_grdv),
        .mii_grxer  (mii_grxer),
        .pdm0_l     (pdm0_l),
        .pmod       (pmod)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic drive_nibble(input udp_rx_pkg::nibble_t nib, input logic err);
        @(posedge mii_grxck);
        mii_grx   <= nib;
        mii_grdv  <= 1'b1;
        mii_grxer <= err;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge mii_grxck);
            mii_grx   <= '0;
            mii_grdv  <= 1'b0;
            mii_grxer <= 1'b0;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_125mhz && cycles < reset_timeout) begin
            @(negedge mii_grxck);
            cycles++;
        end
        if (rst_125mhz) begin
            $display("Reset was still asserted after %0d cycles", reset_timeout);
            error_count++;
        end
    endtask

    // Random payload of 2 to 4 bytes whose ends differ from the given values
    task automatic fill_payload(input udp_rx_pkg::byte_t avoid_first,
                                input udp_rx_pkg::byte_t avoid_last);
        int                len;
        int                i;
        udp_rx_pkg::byte_t b;
        payload_q.delete();
        rng_state = xorshift32(rng_state);
        len = 2 + int'(rng_state % 32'd3);
        for (i = 0; i < len; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            if (i == 0 && b == avoid_first) begin
                b = ~b;
            end
            if (i == len - 1 && b == avoid_last) begin
                b = ~b;
            end
            payload_q.push_back(b);
        end
    endtask

    task automatic build_frame(input logic [15:0]            ethertype,
                               input udp_rx_pkg::byte_t      proto,
                               input udp_rx_pkg::ipv4_addr_t dest_ip,
                               input udp_rx_pkg::udp_port_t  dest_port);
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        int          i;
        ip_len  = 16'(28 + payload_q.size());
        udp_len = 16'(8 + payload_q.size());
        frame_q.delete();
        // Destination and source MAC
        frame_q = '{8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h80,
                    8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01};
        frame_q.push_back(ethertype[15:8]);
        frame_q.push_back(ethertype[7:0]);
        // IPv4 header, no options
        frame_q.push_back(8'h45);
        frame_q.push_back(8'h00);
        frame_q.push_back(ip_len[15:8]);
        frame_q.push_back(ip_len[7:0]);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h40);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h40);
        frame_q.push_back(proto);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'd192);
        frame_q.push_back(8'd168);
        frame_q.push_back(8'd1);
        frame_q.push_back(8'd10);
        frame_q.push_back(dest_ip[31:24]);
        frame_q.push_back(dest_ip[23:16]);
        frame_q.push_back(dest_ip[15:8]);
        frame_q.push_back(dest_ip[7:0]);
        // UDP header, source port 5000
        frame_q.push_back(8'h13);
        frame_q.push_back(8'h88);
        frame_q.push_back(dest_port[15:8]);
        frame_q.push_back(dest_port[7:0]);
        frame_q.push_back(udp_len[15:8]);
        frame_q.push_back(udp_len[7:0]);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h00);
        for (i = 0; i < payload_q.size(); i++) begin
            frame_q.push_back(payload_q[i]);
        end
    endtask

    // err_nibble is the index of the data nibble after the delimiter that carries mii_grxer
    task automatic send_frame(input logic [15:0]            ethertype,
                              input udp_rx_pkg::byte_t      proto,
                              input udp_rx_pkg::ipv4_addr_t dest_ip,
                              input udp_rx_pkg::udp_port_t  dest_port,
                              input int                     err_nibble);
        int i;
        int nib_idx;
        build_frame(ethertype, proto, dest_ip, dest_port);
        for (i = 0; i < 15; i++) begin
            drive_nibble(4'h5, 1'b0);
        end
        drive_nibble(4'hD, 1'b0);
        nib_idx = 0;
        for (i = 0; i < frame_q.size(); i++) begin
            drive_nibble(frame_q[i][3:0], nib_idx == err_nibble);
            nib_idx++;
            drive_nibble(frame_q[i][7:4], nib_idx == err_nibble);
            nib_idx++;
        end
        idle_cycles(settle_cycles);
    endtask

    task automatic check_led(input udp_rx_pkg::byte_t expected);
        @(negedge mii_grxck);
        check_count++;
        if (pmod !== expected) begin
            $display("[FAIL] %0t: pmod is %02h, expected %02h", $time, pmod, expected);
            error_count++;
        end
    endtask

    // Counts pdm0_l highs over one full accumulator period
    task automatic check_level(input udp_rx_pkg::byte_t expected);
        int highs;
        int i;
        highs = 0;
        for (i = 0; i < 256; i++) begin
            @(negedge mii_grxck);
            if (pdm0_l === 1'b1) begin
                highs++;
            end
        end
        check_count++;
        if (highs != int'(expected)) begin
            $display("[FAIL] %0t: pdm0_l high %0d times in 256 cycles, expected %0d",
                     $time, highs, expected);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, error_count - errors_before);
        end
    endtask

    task automatic send_good_frame();
        fill_payload(led_now, level_now);
        send_frame(good_ethertype, good_proto, good_ip, good_port, no_error);
        check_led(payload_q[0]);
        led_now   = payload_q[0];
        level_now = payload_q[payload_q.size() - 1];
    endtask

    task automatic test_matching_frame();
        int errors_before;
        errors_before = error_count;
        send_good_frame();
        check_level(level_now);
        finish_test("matching_frame", errors_before);
    endtask

    task automatic test_wrong_port();
        int errors_before;
        errors_before = error_count;
        fill_payload(led_now, level_now);
        send_frame(good_ethertype, good_proto, good_ip, 16'd1235, no_error);
        check_led(led_now);
        check_level(level_now);
        finish_test("wrong_port", errors_before);
    endtask

    task automatic test_wrong_headers();
        int errors_before;
        errors_before = error_count;
        // ARP ethertype
        fill_payload(led_now, level_now);
        send_frame(16'h0806, good_proto, good_ip, good_port, no_error);
        check_led(led_now);
        check_level(level_now);
        // TCP instead of UDP
        fill_payload(led_now, level_now);
        send_frame(good_ethertype, 8'd6, good_ip, good_port, no_error);
        check_led(led_now);
        check_level(level_now);
        // Neighbouring host address
        fill_payload(led_now, level_now);
        send_frame(good_ethertype, good_proto, {8'd192, 8'd168, 8'd1, 8'd129},
                   good_port, no_error);
        check_led(led_now);
        check_level(level_now);
        finish_test("wrong_headers", errors_before);
    endtask

    task automatic test_header_error();
        int errors_before;
        errors_before = error_count;
        // mii_grxer on the high nibble of the IP checksum low byte
        fill_payload(led_now, level_now);
        send_frame(good_ethertype, good_proto, good_ip, good_port, 51);
        check_led(led_now);
        check_level(level_now);
        send_good_frame();
        check_level(level_now);
        finish_test("header_error", errors_before);
    endtask

    task automatic test_dac_level();
        int errors_before;
        int round;
        errors_before = error_count;
        for (round = 0; round < 4; round++) begin
            send_good_frame();
            check_level(level_now);
        end
        finish_test("dac_level", errors_before);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        mii_grx     <= '0;
        mii_grdv    <= 1'b0;
        mii_grxer   <= 1'b0;
        rng_state   = 32'd11128;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        led_now     = 8'h00;
        level_now   = 8'h00;

        wait_reset_release();
        idle_cycles(4);

        test_matching_frame();
        test_wrong_port();
        test_wrong_headers();
        test_header_error();
        test_dac_level();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/udp_rx_pkg.sv
src/mii_rx_assembler.sv
src/udp_header_filter.sv
src/sigma_delta_dac.sv
src/udp_audio_rx_top.sv
bench/tb_clock_gen.sv
bench/tb_udp_audio_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UDP audio receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f \
    --top-module tb_udp_audio_rx \
    -o tb_udp_audio_rx

if ! ./obj_dir/tb_udp_audio_rx > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
    exit 1
fi

if ! grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
